/* verilog/ulpi_pkg.sv */
// ULPI bus-level types and constants, imported by link blocks that build TXCMD or decode RXCMD
package ulpi_pkg;

    // PHY register address, the low six bits of a TXCMD byte
    localparam int ulpi_addr_w = 6;
    typedef logic [ulpi_addr_w-1:0] ulpi_addr_t;

    // Command code that sits in bits 7:6 of a TXCMD byte
    // Transmit (2'b01) is not used by this link
    typedef enum logic [1:0] {
        txcmd_idle      = 2'b00,
        txcmd_reg_write = 2'b10,
        txcmd_reg_read  = 2'b11
    } txcmd_t;

    // Byte driven while the link owns the bus with nothing to send
    localparam logic [7:0] ulpi_idle_byte = {txcmd_idle, 6'b000000};

    // RXCMD status byte as sent by the PHY
    // Declared MSB first, so line_state lands in bits 1:0
    typedef struct packed {
        // Alternate interrupt source
        logic       alt_int;
        // ID pin state
        logic       id;
        // RxActive / RxError encoding
        logic [1:0] rx_event;
        // VBUS comparator levels
        logic [1:0] vbus_state;
        // D+ / D- line state
        logic [1:0] line_state;
    } rxcmd_t;

endpackage

/* verilog/link_pkg.sv */
// Link-side request and response records passed between the user port and the bus sequencer
package link_pkg;

    // One register access waiting for the bus
    typedef struct packed {
        // Read when set, write when clear
        logic                 is_read;
        // Target PHY register
        ulpi_pkg::ulpi_addr_t addr;
        // Write byte, zero for reads
        logic [7:0]           wdata;
    } reg_req_t;

    // One finished register access
    typedef struct packed {
        // Copy of is_read from the request
        logic                 was_read;
        // Register that was accessed
        ulpi_pkg::ulpi_addr_t addr;
        // Byte returned by the PHY
        // Forced to zero after a write
        logic [7:0]           rdata;
    } reg_resp_t;

endpackage

/* verilog/ulpi_reg_request.sv */
// Request capture stage, turns user read/write strobes into one held request for the sequencer
module ulpi_reg_request (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reg_read,
    input  logic                 reg_write,
    input  ulpi_pkg::ulpi_addr_t reg_addr,
    input  logic [7:0]           reg_write_data,
    input  logic                 req_taken,
    input  logic                 done,
    output link_pkg::reg_req_t   req,
    output logic                 req_valid,
    output logic                 busy
);

    // Strobe accepted only when nothing is in flight
    logic accept;
    // Delayed done, lines up with reg_done at the output stage
    logic done_q;

    assign accept = (reg_read || reg_write) && !busy;

    // Pending flag and transaction flag
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= done;
            if (accept) begin
                req_valid <= 1'b1;
                busy      <= 1'b1;
            end else begin
                // Sequencer picked it up
                if (req_taken) begin
                    req_valid <= 1'b0;
                end
                // Busy ends the cycle after reg_done
                if (done_q) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Request fields, read wins if both strobes fire together
    always_ff @(posedge clk) begin
        if (accept) begin
            req.is_read <= reg_read;
            req.addr    <= reg_addr;
            req.wdata   <= reg_read ? 8'h00 : reg_write_data;
        end
    end

endmodule

/* verilog/ulpi_bus_ctrl.sv */
// ULPI bus sequencer for immediate register read and write, with turnaround, abort and retry
module ulpi_bus_ctrl #(
    parameter int nxt_wait_max = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  link_pkg::reg_req_t  req,
    input  logic                req_valid,
    input  logic                dir,
    input  logic                nxt,
    input  logic [7:0]          data_in,
    output logic                req_taken,
    output logic [7:0]          data_out,
    output logic                data_oe,
    output logic                stp,
    output logic                done,
    output link_pkg::reg_resp_t resp,
    output logic                rx_sample
);

    import ulpi_pkg::*;
    import link_pkg::*;

    // Counter wide enough to reach nxt_wait_max
    localparam int cnt_w = $clog2(nxt_wait_max + 1);

    // idle   bus quiet, waiting for a request
    // load   request held, waiting for a free bus to (re)send TXCMD
    // txcmd  TXCMD on the bus until NXT
    // wdata  write byte on the bus until NXT
    // stp    stop cycle closing a write
    // sync   read turnaround, PHY raises dir
    // save   PHY drives the register byte
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_txcmd,
        st_wdata,
        st_stp,
        st_sync,
        st_save
    } state_t;

    state_t           state;
    reg_req_t         cur;
    logic             dir_q;
    logic [cnt_w-1:0] wait_cnt;
    logic             nxt_timeout;
    logic             bus_free;
    logic             finish_wr;
    logic             finish_rd;

    // TXCMD byte for a request
    function automatic logic [7:0] txcmd_byte(input reg_req_t r);
        txcmd_t code;
        if (r.is_read) begin
            code = txcmd_reg_read;
        end else begin
            code = txcmd_reg_write;
        end
        return {code, r.addr};
    endfunction

    // Bus is ours only when dir has been low for a full cycle
    assign bus_free = !dir && !dir_q;

    // Last allowed cycle of waiting on NXT
    assign nxt_timeout = (wait_cnt == cnt_w'(nxt_wait_max - 1));

    // Start a new request straight from idle
    assign req_taken = (state == st_idle) && req_valid && bus_free;

    assign finish_wr = (state == st_stp);
    assign finish_rd = (state == st_save);

    // No drive while PHY owns the bus or during either turnaround
    assign data_oe = !dir && !dir_q;

    // RXCMD cycle: PHY owns bus, no NXT, past turnaround, not read data
    assign rx_sample = dir && dir_q && !nxt && (state != st_save);

    // Sequencer control
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            data_out <= ulpi_idle_byte;
            stp      <= 1'b0;
            done     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            stp  <= 1'b0;
            done <= finish_wr || finish_rd;
            case (state)
                st_idle: begin
                    if (req_taken) begin
                        data_out <= txcmd_byte(req);
                        wait_cnt <= '0;
                        state    <= st_txcmd;
                    end
                end
                st_load: begin
                    // Retry path after abort or NXT timeout
                    if (bus_free) begin
                        data_out <= txcmd_byte(cur);
                        wait_cnt <= '0;
                        state    <= st_txcmd;
                    end
                end
                st_txcmd: begin
                    if (dir || (!nxt && nxt_timeout)) begin
                        // PHY took the bus, or NXT never came
                        data_out <= ulpi_idle_byte;
                        state    <= st_load;
                    end else if (nxt) begin
                        wait_cnt <= '0;
                        if (cur.is_read) begin
                            data_out <= ulpi_idle_byte;
                            state    <= st_sync;
                        end else begin
                            data_out <= cur.wdata;
                            state    <= st_wdata;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_wdata: begin
                    if (dir || (!nxt && nxt_timeout)) begin
                        data_out <= ulpi_idle_byte;
                        state    <= st_load;
                    end else if (nxt) begin
                        // Data accepted, close with stp and idle data
                        data_out <= ulpi_idle_byte;
                        stp      <= 1'b1;
                        state    <= st_stp;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_stp: begin
                    state <= st_idle;
                end
                st_sync: begin
                    // Turnaround cycle, PHY should have raised dir
                    if (dir) begin
                        state <= st_save;
                    end else if (nxt_timeout) begin
                        state <= st_load;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_save: begin
                    // dir falls next cycle, idle waits for bus_free
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Previous dir, held request and response record
    always_ff @(posedge clk) begin
        dir_q <= dir;
        if (req_taken) begin
            cur <= req;
        end
        if (finish_wr || finish_rd) begin
            resp.was_read <= cur.is_read;
            resp.addr     <= cur.addr;
            resp.rdata    <= finish_rd ? data_in : 8'h00;
        end
    end

endmodule

/* verilog/ulpi_rx_status.sv */
// Output register stage, holds the last RXCMD and the last register response for the user
module ulpi_rx_status (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx_sample,
    input  logic [7:0]          data_in,
    input  logic                done,
    input  link_pkg::reg_resp_t resp,
    output ulpi_pkg::rxcmd_t    rxcmd,
    output logic                rxcmd_valid,
    output link_pkg::reg_resp_t reg_resp,
    output logic                reg_done
);

    import ulpi_pkg::*;

    // One-cycle flags, follow their strobes by a cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rxcmd_valid <= 1'b0;
            reg_done    <= 1'b0;
        end else begin
            rxcmd_valid <= rx_sample;
            reg_done    <= done;
        end
    end

    // Status byte, held until the PHY sends the next one
    always_ff @(posedge clk) begin
        if (rx_sample) begin
            rxcmd <= rxcmd_t'(data_in);
        end
    end

    // Response record, stable from reg_done to the next reg_done
    always_ff @(posedge clk) begin
        if (done) begin
            reg_resp <= resp;
        end
    end

endmodule

/* verilog/ulpi_link.sv */
// Top level of the ULPI link, connect data_in/data_out/data_oe to the PHY DATA pads outside
module ulpi_link #(
    parameter int nxt_wait_max = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reg_read,
    input  logic                 reg_write,
    input  ulpi_pkg::ulpi_addr_t reg_addr,
    input  logic [7:0]           reg_write_data,
    input  logic                 dir,
    input  logic                 nxt,
    input  logic [7:0]           data_in,
    output logic [7:0]           data_out,
    output logic                 data_oe,
    output logic                 stp,
    output logic                 busy,
    output link_pkg::reg_resp_t  reg_resp,
    output logic                 reg_done,
    output ulpi_pkg::rxcmd_t     rxcmd,
    output logic                 rxcmd_valid
);

    import link_pkg::*;

    // Request path
    reg_req_t  req;
    logic      req_valid;
    logic      req_taken;
    // Completion and status path
    reg_resp_t resp;
    logic      done;
    logic      rx_sample;

    ulpi_reg_request u_reg_request (
        .clk            (clk),
        .reset          (reset),
        .reg_read       (reg_read),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_write_data (reg_write_data),
        .req_taken      (req_taken),
        .done           (done),
        .req            (req),
        .req_valid      (req_valid),
        .busy           (busy)
    );

    ulpi_bus_ctrl #(
        .nxt_wait_max (nxt_wait_max)
    ) u_bus_ctrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .dir       (dir),
        .nxt       (nxt),
        .data_in   (data_in),
        .req_taken (req_taken),
        .data_out  (data_out),
        .data_oe   (data_oe),
        .stp       (stp),
        .done      (done),
        .resp      (resp),
        .rx_sample (rx_sample)
    );

    ulpi_rx_status u_rx_status (
        .clk         (clk),
        .reset       (reset),
        .rx_sample   (rx_sample),
        .data_in     (data_in),
        .done        (done),
        .resp        (resp),
        .rxcmd       (rxcmd),
        .rxcmd_valid (rxcmd_valid),
        .reg_resp    (reg_resp),
        .reg_done    (reg_done)
    );

endmodule

/* sim/tb_clock.sv */
// Free-running testbench clock, instantiate once and take clk from its output
module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period high, half period low
    always #(period / 2) clk = ~clk;

endmodule

/* sim/ulpi_link_asserts.sv */
// Concurrent checks of the ULPI bus rules, bound onto every ulpi_link instance
module ulpi_link_asserts (
    input logic clk,
    input logic reset,
    input logic dir,
    input logic data_oe,
    input logic stp,
    input logic busy,
    input logic reg_done
);

    // Link must release DATA while the PHY owns it
    a_no_drive_on_dir: assert property (@(posedge clk) disable iff (reset) dir |-> !data_oe)
        else $error("data_oe high while dir high");

    // stp lasts one cycle only
    a_stp_single: assert property (@(posedge clk) disable iff (reset) stp |=> !stp)
        else $error("stp held longer than one cycle");

    // Completion only inside an accepted transaction
    a_done_in_txn: assert property (@(posedge clk) disable iff (reset) reg_done |-> busy)
        else $error("reg_done without a request in flight");

endmodule

bind ulpi_link ulpi_link_asserts u_link_asserts (
    .clk      (clk),
    .reset    (reset),
    .dir      (dir),
    .data_oe  (data_oe),
    .stp      (stp),
    .busy     (busy),
    .reg_done (reg_done)
);

/* sim/tb_ulpi_link.sv */
// Simulation top for ulpi_link with a PHY bus model, random register traffic and RXCMD checks
module tb_ulpi_link;

    import ulpi_pkg::*;
    import link_pkg::*;

    localparam int n_pairs = 24;
    localparam int timeout_cycles = 200;

    // PHY model states
    localparam int ph_idle = 0;
    localparam int ph_cmd_wait = 1;
    localparam int ph_wr_data = 2;
    localparam int ph_wr_stp = 3;
    localparam int ph_rd_turn = 4;
    localparam int ph_rd_data = 5;
    localparam int ph_rd_back = 6;
    localparam int ph_rx_data = 7;
    localparam int ph_rx_back = 8;

    logic        clk;
    logic        reset;
    logic        reg_read;
    logic        reg_write;
    ulpi_addr_t  reg_addr;
    logic [7:0]  reg_write_data;
    logic        dir;
    logic        nxt;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic        data_oe;
    logic        stp;
    logic        busy;
    reg_resp_t   reg_resp;
    logic        reg_done;
    rxcmd_t      rxcmd;
    logic        rxcmd_valid;

    integer      seed;
    int          errors;
    // Vendor and product ID bytes at addresses 0 to 3
    logic [7:0]  id_bytes [0:3];
    logic [7:0]  phy_regs [0:63];
    rxcmd_t      rx_expect [$];
    int          rx_seen;
    // Precomputed random stimulus
    ulpi_addr_t  addr_list [0:n_pairs-1];
    logic [7:0]  data_list [0:n_pairs-1];
    logic        abort_list [0:n_pairs-1];
    // Set by the driver to abort the first TXCMD of request req_id
    logic        abort_want;
    int          req_id;
    logic        rx_enable;
    // PHY model state
    int          phy_st;
    int          phy_cnt;
    logic        cmd_read;
    ulpi_addr_t  cmd_addr;
    logic [7:0]  wr_val;
    int          abort_used_id;

    tb_clock #(.period(8)) u_clock (.clk(clk));

    ulpi_link #(.nxt_wait_max(16)) u_ulpi_link (
        .clk            (clk),
        .reset          (reset),
        .reg_read       (reg_read),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_write_data (reg_write_data),
        .dir            (dir),
        .nxt            (nxt),
        .data_in        (data_in),
        .data_out       (data_out),
        .data_oe        (data_oe),
        .stp            (stp),
        .busy           (busy),
        .reg_resp       (reg_resp),
        .reg_done       (reg_done),
        .rxcmd          (rxcmd),
        .rxcmd_valid    (rxcmd_valid)
    );

    task automatic report_failure(input string msg);
        errors++;
        $display("%s (time %0t)", msg, $time);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_resp(input string name, input reg_resp_t got, input reg_resp_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("register response differs from model");
        end
    endtask

    task automatic compare_rxcmd(input string name, input rxcmd_t got, input rxcmd_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("RXCMD fields differ from the byte sent");
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure("control output has the wrong level");
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("byte value differs from the expected one");
        end
    endtask

    // Value a read should return after writing wd
    function automatic logic [7:0] expected_read(input ulpi_addr_t a, input logic [7:0] wd);
        if (a < 6'd4) begin
            return id_bytes[a[1:0]];
        end
        return wd;
    endfunction

    // One register access up to the negedge that shows reg_done
    task automatic run_access(input logic rd, input ulpi_addr_t a, input logic [7:0] wd,
                              input logic ab);
        int t;
        t = 0;
        while (busy) begin
            @(negedge clk);
            t++;
            if (t > timeout_cycles) begin
                report_failure("busy never dropped before the next request");
            end
        end
        abort_want     = ab;
        req_id         = req_id + 1;
        reg_read       = rd;
        reg_write      = !rd;
        reg_addr       = a;
        reg_write_data = wd;
        @(negedge clk);
        reg_read  = 1'b0;
        reg_write = 1'b0;
        t = 0;
        while (!reg_done) begin
            @(negedge clk);
            t++;
            if (t > timeout_cycles) begin
                report_failure("reg_done never came for a register access");
            end
        end
        abort_want = 1'b0;
    endtask

    // Write then read back one address
    task automatic write_read(input ulpi_addr_t a, input logic [7:0] wd, input logic ab);
        run_access(1'b0, a, wd, ab);
        compare_resp("reg_resp", reg_resp, reg_resp_t'{was_read: 1'b0, addr: a, rdata: 8'h00});
        compare_byte("phy_regs", phy_regs[a], expected_read(a, wd));
        run_access(1'b1, a, 8'h00, 1'b0);
        compare_resp("reg_resp", reg_resp,
                     reg_resp_t'{was_read: 1'b1, addr: a, rdata: expected_read(a, wd)});
    endtask

    // PHY bus model driving dir, nxt and data_in on the falling edge
    always @(negedge clk) begin
        logic [7:0] r;
        rxcmd_t     e;
        if (reset) begin
            phy_st  = ph_idle;
            dir     = 1'b0;
            nxt     = 1'b0;
            data_in = 8'h00;
        end else begin
            case (phy_st)
                ph_idle: begin
                    if (data_oe && data_out[7:6] != 2'b00) begin
                        cmd_read = data_out[6];
                        cmd_addr = data_out[5:0];
                        if (abort_want && abort_used_id != req_id) begin
                            // Take the bus over the TXCMD before NXT
                            abort_used_id = req_id;
                            dir    = 1'b1;
                            phy_st = ph_rx_data;
                        end else begin
                            phy_cnt = $unsigned($random(seed)) % 4;
                            phy_st  = ph_cmd_wait;
                            if (phy_cnt == 0) begin
                                nxt    = 1'b1;
                                phy_st = cmd_read ? ph_rd_turn : ph_wr_data;
                            end
                        end
                    end else if (rx_enable && ($unsigned($random(seed)) % 8) == 0) begin
                        dir    = 1'b1;
                        phy_st = ph_rx_data;
                    end
                end
                ph_cmd_wait: begin
                    phy_cnt--;
                    if (phy_cnt == 0) begin
                        nxt    = 1'b1;
                        phy_st = cmd_read ? ph_rd_turn : ph_wr_data;
                    end
                end
                ph_wr_data: begin
                    // NXT stays high to take the data byte
                    wr_val = data_out;
                    phy_st = ph_wr_stp;
                end
                ph_wr_stp: begin
                    if (stp) begin
                        nxt = 1'b0;
                        // ID registers are read-only
                        if (cmd_addr >= 6'd4) begin
                            phy_regs[cmd_addr] = wr_val;
                        end
                        phy_st = ph_idle;
                    end
                end
                ph_rd_turn: begin
                    nxt    = 1'b0;
                    dir    = 1'b1;
                    phy_st = ph_rd_data;
                end
                ph_rd_data: begin
                    data_in = phy_regs[cmd_addr];
                    phy_st  = ph_rd_back;
                end
                ph_rx_data: begin
                    // Random status byte, fields placed by the ULPI layout
                    r            = 8'($random(seed));
                    e.line_state = r[1:0];
                    e.vbus_state = r[3:2];
                    e.rx_event   = r[5:4];
                    e.id         = r[6];
                    e.alt_int    = r[7];
                    data_in      = r;
                    rx_expect.push_back(e);
                    phy_st = ph_rx_back;
                end
                ph_rd_back, ph_rx_back: begin
                    // Hand the bus back to the link
                    dir     = 1'b0;
                    data_in = 8'h00;
                    phy_st  = ph_idle;
                end
                default: begin
                    phy_st = ph_idle;
                end
            endcase
        end
    end

    // RXCMD checker
    always @(negedge clk) begin
        rxcmd_t exp;
        if (!reset && rxcmd_valid) begin
            if (rx_expect.size() == 0) begin
                report_failure("rxcmd_valid came without an RXCMD from the PHY");
            end else begin
                exp = rx_expect.pop_front();
                compare_rxcmd("rxcmd", rxcmd, exp);
                rx_seen++;
            end
        end
    end

    initial begin
        int t;
        seed           = 19432;
        errors         = 0;
        rx_seen        = 0;
        req_id         = 0;
        abort_used_id  = -1;
        abort_want     = 1'b0;
        rx_enable      = 1'b0;
        reset          = 1'b1;
        reg_read       = 1'b0;
        reg_write      = 1'b0;
        reg_addr       = '0;
        reg_write_data = 8'h00;
        dir            = 1'b0;
        nxt            = 1'b0;
        data_in        = 8'h00;
        id_bytes[0]    = 8'h24;
        id_bytes[1]    = 8'h04;
        id_bytes[2]    = 8'h04;
        id_bytes[3]    = 8'h00;
        for (int i = 0; i < 64; i++) begin
            phy_regs[i] = (i < 4) ? id_bytes[i % 4] : (8'(i) ^ 8'ha5);
        end
        for (int i = 0; i < n_pairs; i++) begin
            addr_list[i]  = 6'($random(seed));
            data_list[i]  = 8'($random(seed));
            abort_list[i] = ($random(seed) & 3) == 0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_bit("stp", stp, 1'b0);
        compare_bit("busy", busy, 1'b0);
        compare_bit("reg_done", reg_done, 1'b0);
        compare_bit("rxcmd_valid", rxcmd_valid, 1'b0);
        compare_bit("data_oe", data_oe, !dir);
        // Idle byte is the idle code with a zero address field
        compare_byte("data_out", data_out, 8'h00);
        rx_enable = 1'b1;
        for (int i = 0; i < n_pairs; i++) begin
            write_read(addr_list[i], data_list[i], abort_list[i]);
        end
        // ID registers ignore writes
        for (int i = 0; i < 4; i++) begin
            write_read(6'(i), 8'hff - 8'(i), i[0]);
        end
        rx_enable = 1'b0;
        t = 0;
        while (rx_expect.size() != 0 || phy_st != ph_idle) begin
            @(negedge clk);
            t++;
            if (t > timeout_cycles) begin
                report_failure("a sent RXCMD was never reported on rxcmd_valid");
            end
        end
        if (rx_seen == 0) begin
            report_failure("the PHY model sent no RXCMD during the run");
        end
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors found");
        end
    end

endmodule

/* verilog.f */
verilog/ulpi_pkg.sv
verilog/link_pkg.sv
verilog/ulpi_reg_request.sv
verilog/ulpi_bus_ctrl.sv
verilog/ulpi_rx_status.sv
verilog/ulpi_link.sv
sim/tb_clock.sv
sim/ulpi_link_asserts.sv
sim/tb_ulpi_link.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ulpi_link
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
